// File: verilog.f
design/afifo_pkg.sv
design/afifo_mem.sv
design/afifo_wptr.sv
design/afifo_rptr.sv
design/cdc_afifo.sv
tb/tb_afifo.sv

// File: run.sh
#!/bin/sh
# Build the async FIFO testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_afifo -f verilog.f \
  || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/Vtb_afifo 2>&1)
printf '%s\n' "$out"

# Pass only when the testbench printed its pass line
printf '%s\n' "$out" | grep -qx "TB PASSED" && exit 0 || exit 1

// File: tb/tb_afifo.sv
// Async FIFO testbench
// Two drifting clocks, scoreboard and checking assertions

`timescale 1ns/1ps
`default_nettype none

module tb_afifo
  import afifo_pkg::*;
();

  localparam int SEED           = 42005;
  localparam int RESET_CYCLES   = 4;
  localparam int PHASE_CYCLES   = 600;
  localparam int MIX_CYCLES     = 800;
  localparam int FILL_LIMIT     = 8;
  localparam int DRAIN_LIMIT    = 12;
  // About twice the summed phase lengths in rclk cycles
  localparam int TIMEOUT_CYCLES = 2 * (2 * PHASE_CYCLES + MIX_CYCLES);

  // Clocks start low with no event at time zero
  logic rclk = 1'b0;
  logic wclk = 1'b0;

  // DUT inputs and outputs
  logic                 i_wrst;
  logic                 i_wr;
  logic [DATA_BITS-1:0] i_wdata;
  logic                 o_wfull;
  logic                 i_rst;
  logic                 i_rd;
  logic [DATA_BITS-1:0] o_rdata;
  logic                 o_rempty;

  // Strobe rates in percent per phase
  int wr_pct = 0;
  int rd_pct = 0;
  int wr_seed = SEED;
  int rd_seed = SEED + 1;

  // Scoreboard keeps every accepted word in order
  logic [DATA_BITS-1:0] sent_q [$];
  int                   wr_count = 0;
  int                   rd_count = 0;
  logic [DATA_BITS-1:0] head_word;

  // Phase windows for the fill and drain deadlines
  logic fill_check = 1'b0;
  logic drain_check = 1'b0;
  int   fill_cycles = 0;
  int   drain_cycles = 0;
  int   cycle_cnt = 0;

  // One counter per check
  int err_rst_r = 0;
  int err_rst_w = 0;
  int err_data = 0;
  int err_pop = 0;
  int err_level = 0;
  int err_full = 0;
  int err_empty = 0;
  int err_fill = 0;
  int err_drain = 0;
  int err_flow = 0;

  cdc_afifo u_dut (
    .wclk     (wclk),
    .i_wrst   (i_wrst),
    .i_wr     (i_wr),
    .i_wdata  (i_wdata),
    .o_wfull  (o_wfull),
    .rclk     (rclk),
    .i_rst    (i_rst),
    .i_rd     (i_rd),
    .o_rdata  (o_rdata),
    .o_rempty (o_rempty)
  );

  // Read clock with a 100 ns period
  initial begin
    forever #50 rclk = ~rclk;
  end

  // Write clock of 62 ns so its edges drift against rclk
  initial begin
    forever #31 wclk = ~wclk;
  end

  // Write side driver on falling wclk
  initial begin
    int roll;
    i_wrst  = 1'b1;
    i_wr    = 1'b0;
    i_wdata = '0;
    repeat (RESET_CYCLES) @(negedge wclk);
    i_wrst = 1'b0;
    forever begin
      @(negedge wclk);
      roll    = $random(wr_seed);
      i_wr    = ((roll & 32'h7fff_ffff) % 100) < wr_pct;
      i_wdata = $random(wr_seed);
    end
  end

  // Read side driver on falling rclk
  initial begin
    int roll;
    i_rst = 1'b1;
    i_rd  = 1'b0;
    repeat (RESET_CYCLES) @(negedge rclk);
    i_rst = 1'b0;
    forever begin
      @(negedge rclk);
      roll = $random(rd_seed);
      i_rd = ((roll & 32'h7fff_ffff) % 100) < rd_pct;
    end
  end

  // Push on an accepted write
  always @(posedge wclk) begin
    if (!i_wrst && i_wr && !o_wfull) begin
      sent_q.push_back(i_wdata);
      wr_count <= wr_count + 1;
    end
  end

  // Pop on an accepted read
  always @(posedge rclk) begin
    if (!i_rst && i_rd && !o_rempty) begin
      rd_count <= rd_count + 1;
    end
  end

  // Oldest word not yet read
  assign head_word = (rd_count < wr_count) ? sent_q[rd_count] : '0;

  // Deadline counters run only inside their windows
  always @(posedge wclk) begin
    fill_cycles <= fill_check ? fill_cycles + 1 : 0;
  end

  always @(posedge rclk) begin
    drain_cycles <= drain_check ? drain_cycles + 1 : 0;
    cycle_cnt    <= cycle_cnt + 1;
  end

  // Levels right after reset
  a_rempty_after_rst : assert property (
    @(posedge rclk) $fell(i_rst) |-> o_rempty
  ) else begin
    err_rst_r++;
    $display("ERR %0t: o_rempty low after read reset", $time);
  end

  a_wfull_after_rst : assert property (
    @(posedge wclk) $fell(i_wrst) |-> !o_wfull
  ) else begin
    err_rst_w++;
    $display("ERR %0t: o_wfull high after write reset", $time);
  end

  // Head word must appear on every pop
  a_read_data : assert property (
    @(posedge rclk) disable iff (i_rst)
    (i_rd && !o_rempty) |-> (o_rdata == head_word)
  ) else begin
    err_data++;
    $display("ERR %0t: o_rdata %h, expected %h", $time, o_rdata, head_word);
  end

  // A pop needs a word in the scoreboard
  a_pop_has_data : assert property (
    @(posedge rclk) disable iff (i_rst)
    (i_rd && !o_rempty) |-> (rd_count < wr_count)
  ) else begin
    err_pop++;
    $display("ERR %0t: read accepted with nothing written", $time);
  end

  a_level_max : assert property (
    @(posedge wclk) disable iff (i_wrst)
    (wr_count - rd_count) <= DEPTH
  ) else begin
    err_level++;
    $display("ERR %0t: %0d words held, more than DEPTH", $time, wr_count - rd_count);
  end

  // Full level seen once all entries hold data
  a_full_at_depth : assert property (
    @(posedge wclk) disable iff (i_wrst)
    (wr_count - rd_count == DEPTH) |-> o_wfull
  ) else begin
    err_full++;
    $display("ERR %0t: o_wfull low with FIFO holding DEPTH words", $time);
  end

  a_empty_when_drained : assert property (
    @(posedge rclk) disable iff (i_rst)
    (wr_count == rd_count) |-> o_rempty
  ) else begin
    err_empty++;
    $display("ERR %0t: o_rempty low with no words outstanding", $time);
  end

  // Deadlines with the other side stopped
  a_fill_in_time : assert property (
    @(posedge wclk) (fill_check && fill_cycles >= FILL_LIMIT) |-> o_wfull
  ) else begin
    err_fill++;
    $display("ERR %0t: o_wfull not set %0d cycles into the fill", $time, FILL_LIMIT);
  end

  a_drain_in_time : assert property (
    @(posedge rclk)
    (drain_check && drain_cycles >= DRAIN_LIMIT) |-> (o_rempty && wr_count == rd_count)
  ) else begin
    err_drain++;
    $display("ERR %0t: FIFO not empty %0d cycles into the drain", $time, DRAIN_LIMIT);
  end

  // Phase sequencing
  // Rates change on rising edges and windows open on falling edges
  initial begin
    int total;
    wait (!i_wrst && !i_rst);
    // Write-heavy fill
    @(posedge wclk);
    wr_pct = 90;
    @(posedge rclk);
    rd_pct = 20;
    repeat (PHASE_CYCLES) @(posedge rclk);
    // Stop reads and let the last read pointer settle across
    rd_pct = 0;
    repeat (3) @(posedge rclk);
    @(posedge wclk);
    wr_pct = 100;
    @(negedge wclk);
    fill_check = 1'b1;
    repeat (FILL_LIMIT + 4) @(negedge wclk);
    fill_check = 1'b0;
    // Read-heavy drain
    @(posedge wclk);
    wr_pct = 20;
    @(posedge rclk);
    rd_pct = 90;
    repeat (PHASE_CYCLES) @(posedge rclk);
    // Stop writes and expect empty within the limit
    @(posedge wclk);
    wr_pct = 0;
    repeat (3) @(posedge wclk);
    @(posedge rclk);
    rd_pct = 100;
    @(negedge rclk);
    drain_check = 1'b1;
    repeat (DRAIN_LIMIT + 4) @(negedge rclk);
    drain_check = 1'b0;
    // Balanced mix where reads get a higher rate against the faster wclk
    @(posedge wclk);
    wr_pct = 50;
    @(posedge rclk);
    rd_pct = 80;
    repeat (MIX_CYCLES) @(posedge rclk);
    @(posedge wclk);
    wr_pct = 0;
    @(posedge rclk);
    rd_pct = 0;
    repeat (8) @(posedge rclk);
    if (rd_count < 100) begin
      err_flow++;
      $display("Too few words passed through the FIFO: %0d", rd_count);
    end
    total = err_rst_r + err_rst_w + err_data + err_pop + err_level + err_full
          + err_empty + err_fill + err_drain + err_flow;
    $write("Errors: rst %0d/%0d data %0d pop %0d level %0d full %0d",
           err_rst_r, err_rst_w, err_data, err_pop, err_level, err_full);
    $display(" empty %0d fill %0d drain %0d flow %0d, words %0d",
             err_empty, err_fill, err_drain, err_flow, rd_count);
    if (total == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Run limit in rclk cycles
  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: run did not finish within %0d read clock cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule : tb_afifo

`default_nettype wire

// File: design/cdc_afifo.sv
// Dual-clock asynchronous FIFO
// Four entries, Gray pointer crossing

`timescale 1ns/1ps
`default_nettype none

module cdc_afifo
  import afifo_pkg::*;
(
  // Write clock domain
  input  logic                 wclk,
  input  logic                 i_wrst,
  input  logic                 i_wr,
  input  logic [DATA_BITS-1:0] i_wdata,
  output logic                 o_wfull,
  // Read clock domain
  input  logic                 rclk,
  input  logic                 i_rst,
  input  logic                 i_rd,
  output logic [DATA_BITS-1:0] o_rdata,
  output logic                 o_rempty
);

  // Write side to storage
  logic                 we;
  logic [ADDR_BITS-1:0] waddr;

  // Read side to storage
  logic [ADDR_BITS-1:0] raddr;

  // Registered Gray pointers, the only signals crossing domains
  logic [PTR_BITS-1:0]  wgray;
  logic [PTR_BITS-1:0]  rgray;

  // Storage, written on wclk and read by address
  afifo_mem u_mem (
    .wclk    (wclk),
    .i_we    (we),
    .i_waddr (waddr),
    .i_wdata (i_wdata),
    .i_raddr (raddr),
    .o_rdata (o_rdata)
  );

  // Write pointer and full flag in wclk
  afifo_wptr u_wptr (
    .wclk    (wclk),
    .i_wrst  (i_wrst),
    .i_wr    (i_wr),
    .i_rgray (rgray),
    .o_we    (we),
    .o_waddr (waddr),
    .o_wgray (wgray),
    .o_wfull (o_wfull)
  );

  // Read pointer and empty flag in rclk
  afifo_rptr u_rptr (
    .rclk     (rclk),
    .i_rst    (i_rst),
    .i_rd     (i_rd),
    .i_wgray  (wgray),
    .o_raddr  (raddr),
    .o_rgray  (rgray),
    .o_rempty (o_rempty)
  );

endmodule : cdc_afifo

`default_nettype wire

// File: design/afifo_rptr.sv
// Async FIFO read pointer and empty flag

`timescale 1ns/1ps
`default_nettype none

module afifo_rptr
  import afifo_pkg::*;
(
  input  logic                 rclk,
  input  logic                 i_rst,
  input  logic                 i_rd,
  input  logic [PTR_BITS-1:0]  i_wgray,
  output logic [ADDR_BITS-1:0] o_raddr,
  output logic [PTR_BITS-1:0]  o_rgray,
  output logic                 o_rempty
);

  // Binary read pointer with the wrap bit on top
  logic [PTR_BITS-1:0] rbin;
  logic [PTR_BITS-1:0] rbin_next;
  logic [PTR_BITS-1:0] rgray_next;

  // Write pointer after crossing into rclk
  logic [PTR_BITS-1:0] wgray_sync [SYNC_STAGES];
  logic [PTR_BITS-1:0] wgray_q;

  logic                empty_next;
  logic                r_inc;

  // Pop only while something is there
  // A read against a set empty flag is dropped
  assign r_inc = i_rd & ~o_rempty;

  // Pointer after this cycle's read
  assign rbin_next  = rbin + PTR_BITS'(r_inc);
  assign rgray_next = (rbin_next >> 1) ^ rbin_next;

  assign wgray_q = wgray_sync[SYNC_STAGES-1];

  // Empty when reader catches up with the synced writer
  // Gray pointers match exactly in that case
  assign empty_next = (rgray_next == wgray_q);

  // Pointer registers, head address and empty flag
  always_ff @(posedge rclk) begin
    if (i_rst) begin
      rbin     <= '0;
      o_rgray  <= '0;
      o_raddr  <= '0;
      o_rempty <= 1'b1;
    end else begin
      rbin     <= rbin_next;
      o_rgray  <= rgray_next;
      // Head address loaded from the next pointer
      // so the new head word is there right after a pop
      o_raddr  <= rbin_next[ADDR_BITS-1:0];
      // Rises on the pop that takes the last entry
      o_rempty <= empty_next;
    end
  end

  // Write pointer synchronizer of SYNC_STAGES flops
  always_ff @(posedge rclk) begin
    if (i_rst) begin
      for (int k = 0; k < SYNC_STAGES; k++) begin
        wgray_sync[k] <= '0;
      end
    end else begin
      wgray_sync[0] <= i_wgray;
      for (int k = 1; k < SYNC_STAGES; k++) begin
        wgray_sync[k] <= wgray_sync[k-1];
      end
    end
  end

  // Crossing pointer may only step one bit at a time
  a_rgray_one_bit : assert property (
    @(posedge rclk) disable iff (i_rst)
    $countones(o_rgray ^ $past(o_rgray)) <= 1
  ) else $error("afifo_rptr: read Gray pointer changed more than one bit");

  // No advance while empty whatever the consumer does
  a_no_read_when_empty : assert property (
    @(posedge rclk) disable iff (i_rst)
    o_rempty |=> (rbin == $past(rbin))
  ) else $error("afifo_rptr: read pointer advanced while empty");

endmodule : afifo_rptr

`default_nettype wire

// File: design/afifo_wptr.sv
// Async FIFO write pointer and full flag

`timescale 1ns/1ps
`default_nettype none

module afifo_wptr
  import afifo_pkg::*;
(
  input  logic                 wclk,
  input  logic                 i_wrst,
  input  logic                 i_wr,
  input  logic [PTR_BITS-1:0]  i_rgray,
  output logic                 o_we,
  output logic [ADDR_BITS-1:0] o_waddr,
  output logic [PTR_BITS-1:0]  o_wgray,
  output logic                 o_wfull
);

  // Binary write pointer, wrap bit on top
  logic [PTR_BITS-1:0] wbin;
  logic [PTR_BITS-1:0] wbin_next;
  logic [PTR_BITS-1:0] wgray_next;

  // Read pointer after crossing into wclk
  logic [PTR_BITS-1:0] rgray_sync [SYNC_STAGES];
  logic [PTR_BITS-1:0] rgray_q;

  // Full compare pattern and result
  logic [PTR_BITS-1:0] full_match;
  logic                full_next;
  logic                w_inc;

  // Accept only while not full
  // A write against a set full flag is dropped
  assign w_inc = i_wr & ~o_wfull;

  // Pointer after this cycle's write
  assign wbin_next  = wbin + PTR_BITS'(w_inc);
  assign wgray_next = (wbin_next >> 1) ^ wbin_next;

  // Last synchronizer stage is the usable read pointer
  assign rgray_q = rgray_sync[SYNC_STAGES-1];

  // Full when writer is one lap ahead of reader
  // In Gray code that means the top two bits differ, rest equal
  assign full_match = {~rgray_q[PTR_BITS-1:PTR_BITS-2], rgray_q[PTR_BITS-3:0]};
  assign full_next  = (wgray_next == full_match);

  // Pointer registers and full flag
  always_ff @(posedge wclk) begin
    if (i_wrst) begin
      wbin    <= '0;
      o_wgray <= '0;
      o_wfull <= 1'b0;
    end else begin
      wbin    <= wbin_next;
      // Gray copy is the only thing the read side samples
      o_wgray <= wgray_next;
      // Rises on the write that fills the last entry
      o_wfull <= full_next;
    end
  end

  // Read pointer synchronizer, SYNC_STAGES flops deep
  always_ff @(posedge wclk) begin
    if (i_wrst) begin
      for (int k = 0; k < SYNC_STAGES; k++) begin
        rgray_sync[k] <= '0;
      end
    end else begin
      rgray_sync[0] <= i_rgray;
      for (int k = 1; k < SYNC_STAGES; k++) begin
        rgray_sync[k] <= rgray_sync[k-1];
      end
    end
  end

  // Storage write strobe and address
  // Current pointer names the slot written on this edge
  assign o_we    = w_inc;
  assign o_waddr = wbin[ADDR_BITS-1:0];

  // Crossing pointer may only step one bit at a time
  a_wgray_one_bit : assert property (
    @(posedge wclk) disable iff (i_wrst)
    $countones(o_wgray ^ $past(o_wgray)) <= 1
  ) else $error("afifo_wptr: write Gray pointer changed more than one bit");

  // No advance while full, whatever the producer does
  a_no_write_when_full : assert property (
    @(posedge wclk) disable iff (i_wrst)
    o_wfull |=> (wbin == $past(wbin))
  ) else $error("afifo_wptr: write pointer advanced while full");

endmodule : afifo_wptr

`default_nettype wire

// File: design/afifo_mem.sv
// Async FIFO storage array

`timescale 1ns/1ps
`default_nettype none

module afifo_mem
  import afifo_pkg::*;
(
  input  logic                 wclk,
  input  logic                 i_we,
  input  logic [ADDR_BITS-1:0] i_waddr,
  input  logic [DATA_BITS-1:0] i_wdata,
  input  logic [ADDR_BITS-1:0] i_raddr,
  output logic [DATA_BITS-1:0] o_rdata
);

  // Storage entries, payload only
  logic [DATA_BITS-1:0] mem [DEPTH];

  // Write port in the write clock domain
  // Address and enable come from the write pointer block
  always_ff @(posedge wclk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // Read port is combinational
  // Gives first-word fall-through at the head address
  // Entry at i_raddr is stable while the read side can see it
  assign o_rdata = mem[i_raddr];

  // Producer must present defined data on an accepted write
  a_wdata_known : assert property (
    @(posedge wclk) i_we |-> !$isunknown(i_wdata)
  ) else $error("afifo_mem: unknown write data on accepted write");

endmodule : afifo_mem

`default_nettype wire

// File: design/afifo_pkg.sv
// Async FIFO sizing constants

`default_nettype none

package afifo_pkg;

  // Payload width of one FIFO word
  localparam int DATA_BITS = 32;

  // Address bits into the storage array
  localparam int ADDR_BITS = 2;

  // Pointers carry one extra wrap bit
  // The wrap bit tells full from empty when the addresses match
  localparam int PTR_BITS = ADDR_BITS + 1;

  // Number of storage entries
  localparam int DEPTH = 1 << ADDR_BITS;

  // Flops in each Gray pointer synchronizer
  // Two is the usual minimum for metastability settling
  localparam int SYNC_STAGES = 2;

endpackage : afifo_pkg

`default_nettype wire
